// File: sources.f
+incdir+test
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_decoder.sv
verilog/block_ram.sv
verilog/dma_engine.sv
verilog/bus_fabric_top.sv
test/tb_bus_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tb_bus_fabric -Mdir obj_dir -o tb_bus_fabric
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/tb_bus_fabric)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result is decided by the pass line alone
if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: test/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// ==============================
// Port transactions
// ==============================

// Data port access, request held until ready
task automatic dbus_access(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic check, output logic [31:0] data);
	int waited;
	waited = 0;
	@(posedge clock);
	#1;
	dbus_addr = addr;
	dbus_expect = expected_read(addr);
	dbus_check = check && !write;
	if (write && addr[31:28] == REGION_RAM) begin
		ram_model[addr[RAM_AW+1:2]] = wdata;
	end
	i_dbus_req = '{rw: write, address: addr, wdata: wdata};
	i_dbus_valid = 1'b1;
	do begin
		@(posedge clock);
		#1;
		waited++;
	end while (!o_dbus_rsp.ready && waited < TIMEOUT_CYCLES);
	data = o_dbus_rsp.rdata;
	assert (o_dbus_rsp.ready) else begin
		$display("ERROR: %s data port got no ready for address %h, grant is %s",
			test_name, addr, grant_seen.name());
		timeouts++;
	end
	i_dbus_valid = 1'b0;
endtask

// Instruction port read
task automatic ibus_read(input logic [31:0] addr, output logic [31:0] data);
	int waited;
	waited = 0;
	@(posedge clock);
	#1;
	ibus_addr = addr;
	ibus_expect = expected_read(addr);
	ibus_check = 1'b1;
	i_ibus_req = '{rw: 1'b0, address: addr, wdata: 32'h0};
	i_ibus_valid = 1'b1;
	do begin
		@(posedge clock);
		#1;
		waited++;
	end while (!o_ibus_rsp.ready && waited < TIMEOUT_CYCLES);
	data = o_ibus_rsp.rdata;
	assert (o_ibus_rsp.ready) else begin
		$display("ERROR: %s instruction port got no ready for address %h, grant is %s",
			test_name, addr, grant_seen.name());
		timeouts++;
	end
	i_ibus_valid = 1'b0;
endtask

// ==============================
// DMA helpers
// ==============================

task automatic start_dma(input int src_word, input int dst_word, input int words);
	logic [31:0] data;
	dbus_access(1'b1, dma_reg_addr(DMA_REG_SRC), ram_addr(src_word), 1'b0, data);
	dbus_access(1'b1, dma_reg_addr(DMA_REG_DST), ram_addr(dst_word), 1'b0, data);
	dbus_access(1'b1, dma_reg_addr(DMA_REG_COUNT), 32'(words), 1'b0, data);
	dma_src_model = ram_addr(src_word);
	dma_dst_model = ram_addr(dst_word);
	dma_count_model = 32'(words);
	dma_busy_model = 1'b1;
endtask

// Poll STATUS with gaps so the DMA can win the bus
task automatic wait_dma_done();
	logic [31:0] status;
	int          polls;
	int          i;
	status = 32'h1;
	polls = 0;
	while (status[0] && polls < TIMEOUT_CYCLES) begin
		repeat (4) @(posedge clock);
		dbus_access(1'b0, dma_reg_addr(DMA_REG_STATUS), 32'h0, 1'b0, status);
		polls++;
	end
	assert (!status[0]) else begin
		$display("ERROR: %s DMA copy still busy after %0d status polls", test_name, polls);
		timeouts++;
	end
	// Copy finished, replay it on the models
	for (i = 0; i < dma_count_model; i++) begin
		ram_model[dma_dst_model[RAM_AW+1:2]] = ram_model[dma_src_model[RAM_AW+1:2]];
		dma_src_model += 32'd4;
		dma_dst_model += 32'd4;
	end
	dma_count_model = 32'h0;
	dma_busy_model = 1'b0;
endtask

// Registers and destination words after a copy
task automatic check_dma_result(input int dst_word, input int words);
	logic [31:0] data;
	int          i;
	for (i = 0; i < 4; i++) begin
		dbus_access(1'b0, dma_reg_addr(i[1:0]), 32'h0, 1'b1, data);
	end
	for (i = 0; i < words; i++) begin
		dbus_access(1'b0, ram_addr(dst_word + i), 32'h0, 1'b1, data);
	end
endtask

`endif

// File: test/tb_bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_fabric;
	import bus_pkg::*;
	import soc_map_pkg::*;

	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam int TIMEOUT_CYCLES = 200;
	localparam logic [31:0] RAM_BASE = {REGION_RAM, 28'h0};
	localparam logic [31:0] DMA_BASE = {REGION_DMA, 28'h0};

	logic        clock;
	logic        i_rst_n;
	logic        i_ibus_valid;
	bus_req_t    i_ibus_req;
	bus_rsp_t    o_ibus_rsp;
	logic        i_dbus_valid;
	bus_req_t    i_dbus_req;
	bus_rsp_t    o_dbus_rsp;
	master_sel_t grant_seen;

	// Models of the RAM and the DMA registers
	logic [31:0] ram_model [RAM_WORDS];
	logic [31:0] dma_src_model;
	logic [31:0] dma_dst_model;
	logic [31:0] dma_count_model;
	logic        dma_busy_model;

	// Per-port expectation for the compare process
	string       test_name;
	logic        dbus_check;
	logic        ibus_check;
	logic [31:0] dbus_addr;
	logic [31:0] ibus_addr;
	logic [31:0] dbus_expect;
	logic [31:0] ibus_expect;
	int          checks;
	int          errors;
	int          timeouts;

	bus_fabric_top bus_fabric_top_inst (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_ibus_valid (i_ibus_valid),
		.i_ibus_req   (i_ibus_req),
		.o_ibus_rsp   (o_ibus_rsp),
		.i_dbus_valid (i_dbus_valid),
		.i_dbus_req   (i_dbus_req),
		.o_dbus_rsp   (o_dbus_rsp)
	);

	// Arbiter grant state for messages
	assign grant_seen = bus_fabric_top_inst.bus_arbiter_inst.grant;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [31:0] ram_addr(input int word);
		return RAM_BASE + 32'(word) * 32'd4;
	endfunction

	function automatic logic [31:0] dma_reg_addr(input logic [1:0] sel);
		return DMA_BASE | {28'h0, sel, 2'b00};
	endfunction

	// Read result from the address map rules
	function automatic logic [31:0] expected_read(input logic [31:0] addr);
		case (addr[31:28])
			REGION_RAM: return ram_model[addr[RAM_AW+1:2]];
			REGION_DMA: begin
				case (addr[3:2])
					DMA_REG_SRC: return dma_src_model;
					DMA_REG_DST: return dma_dst_model;
					DMA_REG_COUNT: return dma_count_model;
					default: return {31'h0, dma_busy_model};
				endcase
			end
			default: return 32'h0;
		endcase
	endfunction

	`include "tb_bus_tasks.svh"

	// Compare on the falling edge where ready is stable
	always @(negedge clock) begin
		if (o_dbus_rsp.ready && dbus_check) begin
			checks++;
			assert (o_dbus_rsp.rdata == dbus_expect) else begin
				$display("FAIL %s dbus addr %h expected %h actual %h",
					test_name, dbus_addr, dbus_expect, o_dbus_rsp.rdata);
				errors++;
			end
		end
		if (o_ibus_rsp.ready && ibus_check) begin
			checks++;
			assert (o_ibus_rsp.rdata == ibus_expect) else begin
				$display("FAIL %s ibus addr %h expected %h actual %h",
					test_name, ibus_addr, ibus_expect, o_ibus_rsp.rdata);
				errors++;
			end
		end
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [31:0] data;
		logic [31:0] idata;
		int          idx;
		void'($urandom(32'h26733c2f));
		i_rst_n = 1'b0;
		i_ibus_valid = 1'b0;
		i_ibus_req = '0;
		i_dbus_valid = 1'b0;
		i_dbus_req = '0;
		dbus_check = 1'b0;
		ibus_check = 1'b0;
		test_name = "reset";
		repeat (8) @(posedge clock);
		#1;
		i_rst_n = 1'b1;

		test_name = "dbus_ram_rw";
		for (idx = 0; idx < 128; idx++) begin
			dbus_access(1'b1, ram_addr(idx), $urandom, 1'b1, data);
		end
		repeat (32) dbus_access(1'b0, ram_addr($urandom_range(127)), 32'h0, 1'b1, data);

		test_name = "ibus_ram_read";
		repeat (32) ibus_read(ram_addr($urandom_range(127)), idata);

		// Every region except RAM and DMA
		test_name = "unmapped";
		dbus_access(1'b1, 32'h3000_0040, 32'hdead_beef, 1'b1, data);
		for (idx = 0; idx < 16; idx++) begin
			if (idx[3:0] != REGION_RAM && idx[3:0] != REGION_DMA) begin
				dbus_access(1'b0, {idx[3:0], 28'h40}, 32'h0, 1'b1, data);
			end
		end
		ibus_read(32'hf000_0100, idata);

		test_name = "dual_port";
		fork
			repeat (64) begin
				if ($urandom_range(1) == 1) begin
					dbus_access(1'b1, ram_addr(256 + $urandom_range(127)), $urandom, 1'b1, data);
				end else begin
					dbus_access(1'b0, ram_addr($urandom_range(127)), 32'h0, 1'b1, data);
				end
				// Idle gap lets the instruction port in
				repeat (1 + $urandom_range(2)) @(posedge clock);
			end
			repeat (64) ibus_read(ram_addr($urandom_range(127)), idata);
		join

		test_name = "dma_copy";
		start_dma(0, 512, 16);
		wait_dma_done();
		check_dma_result(512, 16);

		test_name = "dma_with_dbus";
		start_dma(16, 600, 32);
		repeat (24) begin
			idx = 256 + $urandom_range(127);
			dbus_access(1'b1, ram_addr(idx), $urandom, 1'b1, data);
			repeat (2) @(posedge clock);
			dbus_access(1'b0, ram_addr(idx), 32'h0, 1'b1, data);
			repeat (2) @(posedge clock);
		end
		wait_dma_done();
		check_dma_result(600, 32);

		// Let the last compare happen
		repeat (2) @(posedge clock);
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/bus_fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_top (
	input  wire                     clock,
	input  wire                     i_rst_n,

	// Instruction port
	input  wire                     i_ibus_valid,
	input  wire bus_pkg::bus_req_t  i_ibus_req,
	output bus_pkg::bus_rsp_t       o_ibus_rsp,

	// Data port
	input  wire                     i_dbus_valid,
	input  wire bus_pkg::bus_req_t  i_dbus_req,
	output bus_pkg::bus_rsp_t       o_dbus_rsp
);
	import bus_pkg::*;

	// DMA master side
	logic     dma_bus_valid;
	bus_req_t dma_bus_req;
	bus_rsp_t dma_bus_rsp;

	// Shared bus
	logic     bus_request;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// Slaves
	logic     ram_request;
	bus_rsp_t ram_rsp;
	logic     dma_reg_request;
	bus_rsp_t dma_reg_rsp;

	// ==============================
	// Arbiter and decoder
	// ==============================

	bus_arbiter bus_arbiter_inst (
		.clock         (clock),
		.i_rst_n       (i_rst_n),
		.i_ibus_valid  (i_ibus_valid),
		.i_ibus_req    (i_ibus_req),
		.o_ibus_rsp    (o_ibus_rsp),
		.i_dbus_valid  (i_dbus_valid),
		.i_dbus_req    (i_dbus_req),
		.o_dbus_rsp    (o_dbus_rsp),
		.i_dma_valid   (dma_bus_valid),
		.i_dma_req     (dma_bus_req),
		.o_dma_rsp     (dma_bus_rsp),
		.o_bus_request (bus_request),
		.o_bus_req     (bus_req),
		.i_bus_rsp     (bus_rsp)
	);

	bus_decoder bus_decoder_inst (
		.clock             (clock),
		.i_rst_n           (i_rst_n),
		.i_bus_request     (bus_request),
		.i_bus_req         (bus_req),
		.o_bus_rsp         (bus_rsp),
		.o_ram_request     (ram_request),
		.i_ram_rsp         (ram_rsp),
		.o_dma_reg_request (dma_reg_request),
		.i_dma_reg_rsp     (dma_reg_rsp)
	);

	// ==============================
	// Slaves
	// ==============================

	// RAM at region 1
	block_ram block_ram_inst (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (ram_request),
		.i_req     (bus_req),
		.o_rsp     (ram_rsp)
	);

	// DMA registers at region 5, also the third master
	dma_engine dma_engine_inst (
		.clock         (clock),
		.i_rst_n       (i_rst_n),
		.i_reg_request (dma_reg_request),
		.i_reg_req     (bus_req),
		.o_reg_rsp     (dma_reg_rsp),
		.o_bus_valid   (dma_bus_valid),
		.o_bus_req     (dma_bus_req),
		.i_bus_rsp     (dma_bus_rsp)
	);

endmodule

`default_nettype wire

// File: verilog/dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
	input  wire                     clock,
	input  wire                     i_rst_n,

	// Register slave
	input  wire                     i_reg_request,
	input  wire bus_pkg::bus_req_t  i_reg_req,
	output bus_pkg::bus_rsp_t       o_reg_rsp,

	// Bus master towards the arbiter
	output logic                    o_bus_valid,
	output bus_pkg::bus_req_t       o_bus_req,
	input  wire bus_pkg::bus_rsp_t  i_bus_rsp
);
	import soc_map_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write
	} state_t;

	state_t      state;
	logic [31:0] src;
	logic [31:0] dst;
	logic [31:0] count;
	logic [31:0] data_q;
	logic        busy;
	logic        reg_access;
	logic        reg_write;
	logic [1:0]  reg_sel;
	logic        reg_ready;
	logic [31:0] reg_rdata;

	// ==============================
	// Register slave
	// ==============================

	// One access per request, the ready cycle is not a new one
	assign reg_access = i_reg_request && !reg_ready;
	assign reg_write = reg_access && i_reg_req.rw;
	assign reg_sel = i_reg_req.address[3:2];
	assign busy = (state != st_idle);

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			reg_ready <= 1'b0;
		end else begin
			reg_ready <= reg_access;
		end
	end

	always_ff @(posedge clock) begin
		if (reg_access) begin
			case (reg_sel)
				DMA_REG_SRC: reg_rdata <= src;
				DMA_REG_DST: reg_rdata <= dst;
				DMA_REG_COUNT: reg_rdata <= count;
				DMA_REG_STATUS: reg_rdata <= {31'h0, busy};
				default: reg_rdata <= 32'h0;
			endcase
		end
	end

	assign o_reg_rsp = '{ready: reg_ready, rdata: reg_rdata};

	// ==============================
	// Copy state machine
	// ==============================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= st_idle;
			src <= 32'h0;
			dst <= 32'h0;
			count <= 32'h0;
		end else begin
			case (state)
				// Registers only take writes while idle
				st_idle: begin
					if (reg_write) begin
						case (reg_sel)
							DMA_REG_SRC: src <= i_reg_req.wdata;
							DMA_REG_DST: dst <= i_reg_req.wdata;
							DMA_REG_COUNT: begin
								count <= i_reg_req.wdata;
								if (i_reg_req.wdata != 32'h0) begin
									state <= st_read;
								end
							end
							default: ;
						endcase
					end
				end
				st_read: begin
					if (i_bus_rsp.ready) begin
						state <= st_write;
					end
				end
				st_write: begin
					if (i_bus_rsp.ready) begin
						src <= src + 32'd4;
						dst <= dst + 32'd4;
						count <= count - 32'd1;
						// Last word written
						state <= (count == 32'd1) ? st_idle : st_read;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Word in flight between the read and the write
	always_ff @(posedge clock) begin
		if (state == st_read && i_bus_rsp.ready) begin
			data_q <= i_bus_rsp.rdata;
		end
	end

	assign o_bus_valid = busy;
	assign o_bus_req = '{
		rw: (state == st_write),
		address: (state == st_write) ? dst : src,
		wdata: data_q
	};

endmodule

`default_nettype wire

// File: verilog/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram #(
	parameter int WORDS = soc_map_pkg::RAM_WORDS
) (
	input  wire                     clock,
	input  wire                     i_rst_n,
	input  wire                     i_request,
	input  wire bus_pkg::bus_req_t  i_req,
	output bus_pkg::bus_rsp_t       o_rsp
);
	localparam int ADDR_BITS = $clog2(WORDS);

	logic [31:0]          mem [WORDS];
	logic [31:0]          rdata_q;
	logic                 ready_q;
	logic                 access;
	logic [ADDR_BITS-1:0] index;

	// Request is still held in the ready cycle, skip it there
	assign access = i_request && !ready_q;

	// Word index from the bits above the byte offset
	assign index = i_req.address[ADDR_BITS+1:2];

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	// Array and read data
	always_ff @(posedge clock) begin
		if (access) begin
			if (i_req.rw) begin
				mem[index] <= i_req.wdata;
			end
			rdata_q <= mem[index];
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  wire                     clock,
	input  wire                     i_rst_n,

	// Shared bus from the arbiter
	input  wire                     i_bus_request,
	input  wire bus_pkg::bus_req_t  i_bus_req,
	output bus_pkg::bus_rsp_t       o_bus_rsp,

	// Block RAM
	output logic                    o_ram_request,
	input  wire bus_pkg::bus_rsp_t  i_ram_rsp,

	// DMA register block
	output logic                    o_dma_reg_request,
	input  wire bus_pkg::bus_rsp_t  i_dma_reg_rsp
);
	import soc_map_pkg::*;

	logic [3:0] region;
	logic       ram_sel;
	logic       dma_sel;
	logic       unmapped_sel;
	logic       unmapped_ready;

	// Region select on the top nibble
	assign region = i_bus_req.address[31:28];
	assign ram_sel = (region == REGION_RAM);
	assign dma_sel = (region == REGION_DMA);
	assign unmapped_sel = !ram_sel && !dma_sel;

	assign o_ram_request = i_bus_request && ram_sel;
	assign o_dma_reg_request = i_bus_request && dma_sel;

	// Unmapped responder, one pulse per access, writes are dropped
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_bus_request && unmapped_sel && !unmapped_ready;
		end
	end

	// Response mux follows the held address
	always_comb begin
		if (ram_sel) begin
			o_bus_rsp = i_ram_rsp;
		end else if (dma_sel) begin
			o_bus_rsp = i_dma_reg_rsp;
		end else begin
			o_bus_rsp.ready = unmapped_ready;
			o_bus_rsp.rdata = 32'h0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                     clock,
	input  wire                     i_rst_n,

	// Instruction port, read only
	input  wire                     i_ibus_valid,
	input  wire bus_pkg::bus_req_t  i_ibus_req,
	output bus_pkg::bus_rsp_t       o_ibus_rsp,

	// Data port
	input  wire                     i_dbus_valid,
	input  wire bus_pkg::bus_req_t  i_dbus_req,
	output bus_pkg::bus_rsp_t       o_dbus_rsp,

	// DMA master port
	input  wire                     i_dma_valid,
	input  wire bus_pkg::bus_req_t  i_dma_req,
	output bus_pkg::bus_rsp_t       o_dma_rsp,

	// Shared bus towards the decoder
	output logic                    o_bus_request,
	output bus_pkg::bus_req_t       o_bus_req,
	input  wire bus_pkg::bus_rsp_t  i_bus_rsp
);
	import bus_pkg::*;

	master_sel_t grant;

	// ==============================
	// Grant register
	// ==============================

	// Fixed priority dbus, ibus, dma; only taken in an idle cycle
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant <= none;
		end else if (grant == none) begin
			if (i_dbus_valid) begin
				grant <= dbus;
			end else if (i_ibus_valid) begin
				grant <= ibus;
			end else if (i_dma_valid) begin
				grant <= dma;
			end
		end else if (i_bus_rsp.ready) begin
			// Transaction done, back to idle on this edge
			grant <= none;
		end
	end

	// ==============================
	// Request and response routing
	// ==============================

	assign o_bus_request = (grant != none);

	always_comb begin
		case (grant)
			// Instruction port can only read
			ibus: o_bus_req = '{rw: 1'b0, address: i_ibus_req.address, wdata: 32'h0};
			dbus: o_bus_req = i_dbus_req;
			dma: o_bus_req = i_dma_req;
			default: o_bus_req = '0;
		endcase
	end

	// Response goes to the granted port only
	always_comb begin
		o_ibus_rsp = '0;
		o_dbus_rsp = '0;
		o_dma_rsp = '0;
		case (grant)
			ibus: o_ibus_rsp = i_bus_rsp;
			dbus: o_dbus_rsp = i_bus_rsp;
			dma: o_dma_rsp = i_bus_rsp;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// ==============================
	// Address map
	// ==============================

	// Regions on address bits 31 to 28
	localparam logic [3:0] REGION_RAM = 4'h1;
	localparam logic [3:0] REGION_DMA = 4'h5;

	// Block RAM size in 32-bit words
	localparam int RAM_WORDS = 1024;

	// ==============================
	// DMA registers
	// ==============================

	// Word offsets, address bits 3 to 2
	localparam logic [1:0] DMA_REG_SRC    = 2'd0;
	localparam logic [1:0] DMA_REG_DST    = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT  = 2'd2;
	localparam logic [1:0] DMA_REG_STATUS = 2'd3;

endpackage

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// ==============================
	// Shared bus transaction types
	// ==============================

	// Request as a master presents it, held stable until ready
	typedef struct packed {
		logic        rw;        // High means write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Response, ready pulses for one cycle and carries the read data
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// Arbiter grant state
	typedef enum logic [1:0] {
		none,
		ibus,
		dbus,
		dma
	} master_sel_t;

endpackage

`default_nettype wire
